/* project.f */
src/mix_pkg.sv
src/dual_port_ram.sv
src/addr_adder.sv
src/mix_sequencer.sv
src/mac_datapath.sv
src/output_scaler.sv
src/mixer_top.sv
verif/mixer_clock.sv
verif/mixer_tb.sv

/* run.sh */
#!/bin/sh
# Build the mixer testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module mixer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmixer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* src/addr_adder.sv */
// Sample address generator, channel plus frame minus delay offset, registered
`timescale 1ns/10ps

module addr_adder import mix_pkg::*; (
    input  logic               ck,
    input  logic [FRAME_W-1:0] frame,
    input  logic [FRAME_W-1:0] offset,
    input  logic [CHAN_W-1:0]  chan,
    output smp_addr_t          addr
);

    logic [FRAME_W-1:0] tap;

    // Wraps modulo 16 so offset acts as a delay-line tap
    assign tap = frame - offset;

    always_ff @(posedge ck) begin
        addr <= {chan, tap};
    end

endmodule

/* src/dual_port_ram.sv */
// Simple dual-port memory with synchronous write and registered read
`timescale 1ns/10ps

module dual_port_ram #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
) (
    input  logic              ck,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [ADDR_W-1:0] raddr,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data appears one cycle after the address
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

    a_waddr_known: assert property (@(posedge ck) we |-> !$isunknown(waddr));

endmodule

/* src/mac_datapath.sv */
// Multiply-accumulate datapath, sign-magnitude multiply into a 40-bit accumulator
`timescale 1ns/10ps

module mac_datapath import mix_pkg::*; (
    input  logic      ck,
    input  logic      reset,
    input  mac_ctrl_t ctrl,
    input  gain_t     gain,
    input  sample_t   sample,
    output acc_t      acc
);

    logic [SAMPLE_W-1:0] mag_q;
    logic                sign_q;
    gain_t               gain_q;
    mac_ctrl_t           ctrl_q;

    logic [PROD_W-1:0]   prod_q;
    logic                sub_p;
    mac_ctrl_t           ctrl_p;

    acc_t                base;
    acc_t                term;

    // Magnitude of -32768 still fits as unsigned 16 bits
    always_ff @(posedge ck) begin
        mag_q  <= sample[SAMPLE_W-1] ? SAMPLE_W'(-sample) : SAMPLE_W'(sample);
        sign_q <= sample[SAMPLE_W-1];
        gain_q <= gain;
        prod_q <= mag_q * gain_q;
        // Negative sample flips the add/subtract sense
        sub_p  <= ctrl_q.subtract ^ sign_q;
    end

    assign base = ctrl_p.clear ? '0 : acc;
    assign term = acc_t'({{(ACC_W - PROD_W){1'b0}}, prod_q});

    always_ff @(posedge ck) begin
        if (reset) begin
            ctrl_q <= '0;
            ctrl_p <= '0;
            acc    <= '0;
        end else begin
            ctrl_q <= ctrl;
            ctrl_p <= ctrl_q;
            if (ctrl_p.en) begin
                acc <= sub_p ? base - term : base + term;
            end
        end
    end

    a_clear_needs_en: assert property (@(posedge ck) disable iff (reset)
        ctrl.clear |-> ctrl.en);

endmodule

/* src/mix_pkg.sv */
// Mix engine shared package with widths, opcodes, instruction format and pipeline types
package mix_pkg;

    localparam int CHAN_W      = 4;
    localparam int FRAME_W     = 4;
    localparam int SMP_ADDR_W  = CHAN_W + FRAME_W;
    localparam int PROG_ADDR_W = 8;
    localparam int SAMPLE_W    = 16;
    localparam int GAIN_W      = 16;
    localparam int PROD_W      = SAMPLE_W + GAIN_W;
    localparam int ACC_W       = 40;
    localparam int SLOT_W      = 4;
    localparam int INSTR_W     = 32;

    // Stage offsets counted from the decode cycle
    localparam int CTRL_DELAY    = 2;
    localparam int SAVE_DELAY    = 4;
    localparam int FETCH_LATENCY = 2;
    // Fetch of a SAVE to out.we
    localparam int SAVE_LATENCY  = FETCH_LATENCY + SAVE_DELAY + 1;
    // Drain entry and the done register take the last two cycles
    localparam int DRAIN_CYCLES  = SAVE_LATENCY - FETCH_LATENCY - 2;
    localparam int DRAIN_W       = $clog2(DRAIN_CYCLES + 1);

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic        [GAIN_W-1:0]   gain_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic [SMP_ADDR_W-1:0]      smp_addr_t;
    typedef logic [PROG_ADDR_W-1:0]     prog_addr_t;
    typedef logic [SLOT_W-1:0]          slot_t;

    // Saturation limits of a 16-bit sample
    localparam acc_t SAT_MAX = acc_t'(2 ** (SAMPLE_W - 1) - 1);
    localparam acc_t SAT_MIN = -acc_t'(2 ** (SAMPLE_W - 1));

    typedef enum logic [7:0] {
        NOOP  = 8'h00,
        SAVE  = 8'h02,
        MAC   = 8'h80,
        MACZ  = 8'h81,
        MACN  = 8'h82,
        MACNZ = 8'h83,
        HALT  = 8'hFF
    } mix_op_t;

    // For SAVE, offset is the shift and gain[3:0] the output slot
    typedef struct packed {
        mix_op_t              op;
        logic [FRAME_W-1:0]   offset;
        logic [CHAN_W-1:0]    chan;
        gain_t                gain;
    } mix_instr_t;

    typedef struct packed {
        logic en;
        logic clear;
        logic subtract;
    } mac_ctrl_t;

    typedef struct packed {
        logic    we;
        slot_t   slot;
        sample_t audio;
    } mix_out_t;

endpackage

/* src/mix_sequencer.sv */
// Microcode sequencer with program counter, decode, control delay lines and run status
`timescale 1ns/10ps

module mix_sequencer import mix_pkg::*; (
    input  logic               ck,
    input  logic               reset,
    input  logic               start,
    input  logic [FRAME_W-1:0] frame,
    output prog_addr_t         prog_addr,
    input  mix_instr_t         prog_data,
    output smp_addr_t          smp_raddr,
    output mac_ctrl_t          ctrl,
    output gain_t              gain,
    output logic               save_en,
    output logic [FRAME_W-1:0] shift,
    output slot_t              slot,
    output logic               done,
    output logic               error
);

    typedef enum logic [1:0] {IDLE, RUN, DRAIN} seq_state_t;

    seq_state_t         state;
    prog_addr_t         pc;
    logic [FRAME_W-1:0] frame_q;
    logic               data_vld;
    logic               instr_vld;
    mix_instr_t         instr_q;
    logic [DRAIN_W-1:0] drain_cnt;
    logic               err_pend;

    mac_ctrl_t          dec_ctrl;
    logic               dec_save;
    logic               stop;
    logic               illegal;

    mac_ctrl_t          ctrl_pipe  [CTRL_DELAY];
    gain_t              gain_pipe  [CTRL_DELAY];
    logic               save_pipe  [SAVE_DELAY];
    logic [FRAME_W-1:0] shift_pipe [SAVE_DELAY];
    slot_t              slot_pipe  [SAVE_DELAY];

    assign prog_addr = pc;

    // Run control and fetch valid tracking
    always_ff @(posedge ck) begin
        if (reset) begin
            state     <= IDLE;
            pc        <= '0;
            data_vld  <= 1'b0;
            instr_vld <= 1'b0;
            drain_cnt <= '0;
            err_pend  <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            done      <= 1'b0;
            // Anything fetched behind a stop is dropped
            data_vld  <= (state == RUN) && !stop;
            instr_vld <= data_vld && !stop;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        pc       <= '0;
                        error    <= 1'b0;
                        err_pend <= 1'b0;
                    end
                end
                RUN: begin
                    pc <= pc + 1'b1;
                    if (stop) begin
                        state     <= DRAIN;
                        drain_cnt <= DRAIN_W'(DRAIN_CYCLES);
                        err_pend  <= illegal;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == '0) begin
                        state <= IDLE;
                        done  <= 1'b1;
                        error <= err_pend;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (state == IDLE && start) begin
            frame_q <= frame;
        end
        instr_q <= prog_data;
    end

    // Decode of the latched instruction
    always_comb begin
        dec_ctrl = '0;
        dec_save = 1'b0;
        stop     = 1'b0;
        illegal  = 1'b0;
        if (instr_vld) begin
            case (instr_q.op)
                NOOP:  ;
                SAVE:  dec_save = 1'b1;
                MAC:   dec_ctrl = '{en: 1'b1, clear: 1'b0, subtract: 1'b0};
                MACZ:  dec_ctrl = '{en: 1'b1, clear: 1'b1, subtract: 1'b0};
                MACN:  dec_ctrl = '{en: 1'b1, clear: 1'b0, subtract: 1'b1};
                MACNZ: dec_ctrl = '{en: 1'b1, clear: 1'b1, subtract: 1'b1};
                HALT:  stop = 1'b1;
                default: begin
                    stop    = 1'b1;
                    illegal = 1'b1;
                end
            endcase
        end
    end

    // Sample address leaves one cycle after decode, data one cycle later
    addr_adder u_addr_adder (
        .ck     (ck),
        .frame  (frame_q),
        .offset (instr_q.offset),
        .chan   (instr_q.chan),
        .addr   (smp_raddr)
    );

    // MAC control meets the sample at the datapath input
    always_ff @(posedge ck) begin
        if (reset) begin
            for (int i = 0; i < CTRL_DELAY; i++) begin
                ctrl_pipe[i] <= '0;
            end
            for (int i = 0; i < SAVE_DELAY; i++) begin
                save_pipe[i] <= 1'b0;
            end
        end else begin
            ctrl_pipe[0] <= dec_ctrl;
            for (int i = 1; i < CTRL_DELAY; i++) begin
                ctrl_pipe[i] <= ctrl_pipe[i-1];
            end
            save_pipe[0] <= dec_save;
            for (int i = 1; i < SAVE_DELAY; i++) begin
                save_pipe[i] <= save_pipe[i-1];
            end
        end
    end

    always_ff @(posedge ck) begin
        gain_pipe[0]  <= instr_q.gain;
        shift_pipe[0] <= instr_q.offset;
        slot_pipe[0]  <= instr_q.gain[SLOT_W-1:0];
        for (int i = 1; i < CTRL_DELAY; i++) begin
            gain_pipe[i] <= gain_pipe[i-1];
        end
        for (int i = 1; i < SAVE_DELAY; i++) begin
            shift_pipe[i] <= shift_pipe[i-1];
            slot_pipe[i]  <= slot_pipe[i-1];
        end
    end

    assign ctrl    = ctrl_pipe[CTRL_DELAY-1];
    assign gain    = gain_pipe[CTRL_DELAY-1];
    // SAVE reaches the scaler once every earlier MAC is in the accumulator
    assign save_en = save_pipe[SAVE_DELAY-1];
    assign shift   = shift_pipe[SAVE_DELAY-1];
    assign slot    = slot_pipe[SAVE_DELAY-1];

    a_idle_quiet: assert property (@(posedge ck) disable iff (reset)
        (state == IDLE) |-> !save_en && !ctrl.en);
    a_done_empty: assert property (@(posedge ck) disable iff (reset)
        done |-> !save_en && !data_vld && !instr_vld);
    a_error_done: assert property (@(posedge ck) disable iff (reset)
        $rose(error) |-> done);

endmodule

/* src/mixer_top.sv */
// Mixing engine top level joining memories, sequencer, MAC datapath and scaler
`timescale 1ns/10ps

module mixer_top import mix_pkg::*; (
    input  logic               ck,
    input  logic               reset,
    input  logic               start,
    input  logic [FRAME_W-1:0] frame,
    input  logic               prog_we,
    input  prog_addr_t         prog_addr,
    input  logic [INSTR_W-1:0] prog_data,
    input  logic               smp_we,
    input  smp_addr_t          smp_addr,
    input  sample_t            smp_data,
    output mix_out_t           out,
    output logic               done,
    output logic               error
);

    prog_addr_t         fetch_addr;
    mix_instr_t         instr;
    smp_addr_t          smp_raddr;
    sample_t            sample;
    mac_ctrl_t          ctrl;
    gain_t              gain;
    acc_t               acc;
    logic               save_en;
    logic [FRAME_W-1:0] shift;
    slot_t              slot;

    dual_port_ram #(.ADDR_W(PROG_ADDR_W), .DATA_W(INSTR_W)) u_prog_ram (
        .ck(ck), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
        .raddr(fetch_addr), .rdata(instr)
    );

    dual_port_ram #(.ADDR_W(SMP_ADDR_W), .DATA_W(SAMPLE_W)) u_smp_ram (
        .ck(ck), .we(smp_we), .waddr(smp_addr), .wdata(smp_data),
        .raddr(smp_raddr), .rdata(sample)
    );

    mix_sequencer u_seq (
        .ck(ck), .reset(reset), .start(start), .frame(frame),
        .prog_addr(fetch_addr), .prog_data(instr), .smp_raddr(smp_raddr),
        .ctrl(ctrl), .gain(gain), .save_en(save_en), .shift(shift), .slot(slot),
        .done(done), .error(error)
    );

    mac_datapath u_mac (
        .ck(ck), .reset(reset), .ctrl(ctrl), .gain(gain), .sample(sample), .acc(acc)
    );

    output_scaler u_scaler (
        .ck(ck), .reset(reset), .save_en(save_en), .shift(shift), .slot(slot),
        .acc(acc), .out(out)
    );

endmodule

/* src/output_scaler.sv */
// Output scaler, arithmetic shift of the accumulator and saturation to 16 bits
`timescale 1ns/10ps

module output_scaler import mix_pkg::*; (
    input  logic               ck,
    input  logic               reset,
    input  logic               save_en,
    input  logic [FRAME_W-1:0] shift,
    input  slot_t              slot,
    input  acc_t               acc,
    output mix_out_t           out
);

    acc_t    shifted;
    sample_t clamped;

    assign shifted = acc >>> shift;

    always_comb begin
        if (shifted > SAT_MAX) begin
            clamped = sample_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            clamped = sample_t'(SAT_MIN);
        end else begin
            clamped = shifted[SAMPLE_W-1:0];
        end
    end

    // Slot and audio read as zero between writes
    always_ff @(posedge ck) begin
        if (reset) begin
            out <= '0;
        end else begin
            out.we    <= save_en;
            out.slot  <= save_en ? slot : '0;
            out.audio <= save_en ? clamped : '0;
        end
    end

endmodule

/* verif/mixer_clock.sv */
// Testbench clock and reset generator, 40 ns period with reset held for 3 cycles
`timescale 1ns/10ps

module mixer_clock (
    output logic ck,
    output logic reset
);

    initial begin
        ck = 1'b0;
        forever #20 ck = ~ck;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge ck);
        reset <= 1'b0;
    end

endmodule

/* verif/mixer_tb.sv */
// Mixer engine testbench with reference mixing model, output checker and watchdog
`timescale 1ns/10ps

module mixer_tb import mix_pkg::*; ();

    localparam int PERIOD_NS   = 40;
    localparam int NUM_RUNS    = 26;
    localparam int MAX_PROG    = 24;
    localparam int RUN_TIMEOUT = MAX_PROG + 30;
    // Every instruction is loaded, fetched and drained; margin covers sample loads
    localparam int WATCHDOG_NS = (NUM_RUNS * MAX_PROG * 4 + 600) * PERIOD_NS;

    logic               ck;
    logic               reset;
    logic               start;
    logic [FRAME_W-1:0] frame;
    logic               prog_we;
    prog_addr_t         prog_addr;
    logic [INSTR_W-1:0] prog_data;
    logic               smp_we;
    smp_addr_t          smp_addr;
    sample_t            smp_data;
    mix_out_t           out;
    logic               done;
    logic               error;

    // Images of what the DUT memories hold
    logic [INSTR_W-1:0] prog_img [256];
    sample_t            smp_img  [256];
    int                 prog_len;

    mix_out_t           exp_q [$];
    mix_out_t           next_exp;
    logic               exp_err;
    longint             model_acc;
    int                 runs_started;
    int                 runs_done;
    int                 writes_seen;
    logic [31:0]        lfsr = 32'd91734;

    mixer_clock u_clock (.ck(ck), .reset(reset));

    mixer_top DUT (
        .ck(ck), .reset(reset), .start(start), .frame(frame),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .smp_we(smp_we), .smp_addr(smp_addr), .smp_data(smp_data),
        .out(out), .done(done), .error(error)
    );

    task automatic end_failed();
        $display("Verification failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_problem(input string why);
        $display("%0t ns: %s", $time, why);
        end_failed();
    endtask

    task automatic check_equal(input string name, input logic signed [63:0] got,
                               input logic signed [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            end_failed();
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [INSTR_W-1:0] encode(input mix_op_t op, input int offset,
                                                  input int chan, input int gain);
        mix_instr_t w;
        w.op     = op;
        w.offset = offset[3:0];
        w.chan   = chan[3:0];
        w.gain   = gain[15:0];
        return w;
    endfunction

    function automatic void emit(input logic [INSTR_W-1:0] word);
        prog_img[prog_len] = word;
        prog_len++;
    endfunction

    // Walks the program image and queues the writes the engine should make
    function automatic void mix_reference(input logic [FRAME_W-1:0] fr);
        mix_instr_t w;
        int         tap;
        longint     prod;
        longint     v;
        mix_out_t   e;
        exp_err = 1'b0;
        for (int pc = 0; pc < prog_len; pc++) begin
            w = prog_img[pc];
            case (w.op)
                NOOP: ;
                MAC, MACZ, MACN, MACNZ: begin
                    tap  = (int'(fr) + 16 - int'(w.offset)) % 16;
                    prod = longint'(smp_img[w.chan * 16 + tap]) * longint'(w.gain);
                    if (w.op == MACZ || w.op == MACNZ) model_acc = 0;
                    if (w.op == MACN || w.op == MACNZ) model_acc = model_acc - prod;
                    else model_acc = model_acc + prod;
                    // Accumulator wraps at 40 bits
                    model_acc = (model_acc <<< 24) >>> 24;
                end
                SAVE: begin
                    v = model_acc >>> w.offset;
                    if (v > 32767) v = 32767;
                    else if (v < -32768) v = -32768;
                    e.we    = 1'b1;
                    e.slot  = w.gain[3:0];
                    e.audio = v[15:0];
                    exp_q.push_back(e);
                end
                HALT: return;
                default: begin
                    exp_err = 1'b1;
                    return;
                end
            endcase
        end
    endfunction

    task automatic write_sample(input int addr, input logic [15:0] value);
        @(posedge ck);
        smp_we   <= 1'b1;
        smp_addr <= addr[7:0];
        smp_data <= value;
        smp_img[addr] = value;
    endtask

    task automatic put_sample(input int chan, input int fr, input int value);
        write_sample(chan * 16 + fr, value[15:0]);
    endtask

    task automatic write_prog(input int addr, input logic [INSTR_W-1:0] word);
        @(posedge ck);
        prog_we   <= 1'b1;
        prog_addr <= addr[7:0];
        prog_data <= word;
    endtask

    // Loads the program, starts it and waits for done
    task automatic run_program(input logic [FRAME_W-1:0] fr, input bit poke_busy);
        int waited;
        int target;
        for (int i = 0; i < prog_len; i++) begin
            write_prog(i, prog_img[i]);
        end
        mix_reference(fr);
        target = runs_done + 1;
        @(posedge ck);
        prog_we <= 1'b0;
        smp_we  <= 1'b0;
        start   <= 1'b1;
        frame   <= fr;
        runs_started++;
        @(posedge ck);
        start <= 1'b0;
        // Start has been taken, so error is clear for the new run
        @(negedge ck);
        check_equal("error", error, 1'b0);
        if (poke_busy) begin
            // Second start lands while the run is busy
            @(posedge ck);
            start <= 1'b1;
            frame <= fr ^ 4'h5;
            @(posedge ck);
            start <= 1'b0;
        end
        waited = 0;
        while (runs_done < target) begin
            @(posedge ck);
            waited++;
            if (waited > RUN_TIMEOUT) report_problem("timed out waiting for done");
        end
        prog_len = 0;
    endtask

    // Output checker, sampled away from the driving edge
    always @(negedge ck) begin
        if (!reset) begin
            if (out.we) begin
                if (exp_q.size() == 0) begin
                    report_problem("output write arrived with no write expected");
                end else begin
                    next_exp = exp_q.pop_front();
                    check_equal("out.slot", out.slot, next_exp.slot);
                    check_equal("out.audio", out.audio, next_exp.audio);
                    writes_seen++;
                end
            end
            if (done) begin
                if (runs_done >= runs_started) report_problem("done pulsed with no run started");
                if (exp_q.size() != 0) report_problem("done arrived while writes were missing");
                check_equal("error", error, exp_err);
                runs_done++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_problem("watchdog expired before the tests finished");
    end

    initial begin
        logic [1:0] sel;
        int         n;
        start        = 1'b0;
        frame        = '0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        smp_we       = 1'b0;
        smp_addr     = '0;
        smp_data     = '0;
        prog_len     = 0;
        model_acc    = 0;
        exp_err      = 1'b0;
        runs_started = 0;
        runs_done    = 0;
        writes_seen  = 0;
        wait (!reset);
        for (int a = 0; a < 256; a++) begin
            write_sample(a, rand_bits(16));
        end

        // Single term into slot 5
        put_sample(2, 7, 1000);
        emit(encode(MACZ, 0, 2, 3));
        emit(encode(SAVE, 0, 0, 5));
        emit(encode(HALT, 0, 0, 0));
        run_program(4'd7, 1'b0);

        // Signed mix with two saves
        put_sample(1, 9, 120);
        put_sample(3, 9, -90);
        put_sample(4, 9, -300);
        put_sample(5, 9, 45);
        put_sample(6, 9, -1000);
        emit(encode(MACZ, 0, 1, 200));
        emit(encode(MAC, 0, 3, 50));
        emit(encode(MACN, 0, 4, 7));
        emit(encode(SAVE, 0, 0, 1));
        emit(encode(MACNZ, 0, 5, 11));
        emit(encode(MAC, 0, 6, 9));
        emit(encode(SAVE, 0, 0, 2));
        emit(encode(HALT, 0, 0, 0));
        run_program(4'd9, 1'b0);

        // Delay taps around the frame wrap
        put_sample(9, 0, 111);
        put_sample(9, 15, -222);
        put_sample(9, 1, 333);
        emit(encode(MACZ, 0, 9, 1));
        emit(encode(SAVE, 0, 0, 0));
        emit(encode(MACZ, 1, 9, 1));
        emit(encode(SAVE, 0, 0, 1));
        emit(encode(MACZ, 15, 9, 1));
        emit(encode(SAVE, 0, 0, 2));
        emit(encode(HALT, 0, 0, 0));
        run_program(4'd0, 1'b0);

        // Shift and saturation
        put_sample(10, 3, 32767);
        put_sample(11, 3, -32768);
        emit(encode(MACZ, 0, 10, 65535));
        emit(encode(SAVE, 0, 0, 3));
        emit(encode(SAVE, 15, 0, 4));
        emit(encode(MACNZ, 0, 10, 65535));
        emit(encode(SAVE, 0, 0, 5));
        emit(encode(MAC, 0, 11, 65535));
        emit(encode(SAVE, 15, 0, 6));
        emit(encode(MACZ, 0, 10, 4));
        emit(encode(SAVE, 2, 0, 7));
        emit(encode(MACNZ, 0, 11, 1));
        emit(encode(SAVE, 0, 0, 8));
        emit(encode(MACZ, 0, 11, 1));
        emit(encode(SAVE, 0, 0, 9));
        emit(encode(HALT, 0, 0, 0));
        run_program(4'd3, 1'b0);

        // Illegal opcode stops the run with error
        emit(encode(MACZ, 0, 2, 5));
        emit(encode(SAVE, 0, 0, 8));
        emit(encode(mix_op_t'(8'h40), 0, 0, 0));
        emit(encode(SAVE, 0, 0, 9));
        emit(encode(HALT, 0, 0, 0));
        run_program(4'd7, 1'b0);
        @(negedge ck);
        check_equal("error", error, 1);

        // Next start clears error, extra start while busy is ignored
        emit(encode(MACZ, 0, 1, 17));
        for (int i = 0; i < 4; i++) begin
            emit(encode(NOOP, 0, 0, 0));
        end
        emit(encode(SAVE, 0, 0, 12));
        emit(encode(HALT, 0, 0, 0));
        run_program(4'd9, 1'b1);

        // Random programs on random frames
        for (int t = 0; t < 20; t++) begin
            for (int k = 0; k < 4; k++) begin
                write_sample(rand_bits(8), rand_bits(16));
            end
            n = 4 + rand_bits(4);
            for (int i = 0; i < n; i++) begin
                sel = rand_bits(2);
                if (sel == 2'd0) begin
                    emit(encode(SAVE, rand_bits(4), 0, rand_bits(16)));
                end else begin
                    emit(encode(mix_op_t'(8'h80 | rand_bits(2)), rand_bits(4),
                                rand_bits(4), rand_bits(16)));
                end
            end
            emit(encode(HALT, 0, 0, 0));
            run_program(rand_bits(4), 1'b0);
        end

        // Room for any stray write or done
        repeat (20) @(posedge ck);
        if (writes_seen > 0 && exp_q.size() == 0 && runs_done == NUM_RUNS) begin
            $display("Verification passed");
            $finish;
        end else begin
            report_problem("run count or write count does not match the tests");
        end
    end

endmodule
